/* src/vdecode_defines.svh */
`ifndef VDECODE_DEFINES_SVH
`define VDECODE_DEFINES_SVH

// scalar operand width
`define VD_XLEN 32

// element offset into a register group, wraps at 256
`define VD_OFFSET_W 8

// element count and vl width, vl never exceeds 32
`define VD_CNT_W 6

// v0 mask bits, one per element
`define VD_MASK_W 32

// vector register index
`define VD_REG_W 5

`endif

/* src/vdecode_pkg.sv */
`default_nettype none

`include "vdecode_defines.svh"

package vdecode_pkg;

  // vtype element width
  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_t;

  // load/store width field, instr[14:12]
  typedef enum logic [2:0] {
    EEW8  = 3'b000,
    EEW16 = 3'b101,
    EEW32 = 3'b110
  } eew_t;

  typedef enum logic [1:0] {
    OP_ARITH = 2'd0,
    OP_LOAD  = 2'd1,
    OP_STORE = 2'd2,
    OP_MV_SX = 2'd3
  } op_class_t;

  // where the vs2 read offsets come from
  typedef enum logic [1:0] {
    VS2_NORMAL    = 2'd0,
    VS2_PLUS_RS1  = 2'd1,
    VS2_PLUS_UIMM = 2'd2,
    VS2_ZERO      = 2'd3
  } vs2_src_t;

  // where the vd write offsets come from
  typedef enum logic [1:0] {
    VD_NORMAL    = 2'd0,
    VD_PLUS_RS1  = 2'd1,
    VD_PLUS_UIMM = 2'd2,
    VD_ZERO      = 2'd3
  } vd_src_t;

  typedef logic [`VD_OFFSET_W-1:0] offset_t;
  typedef logic [`VD_REG_W-1:0] reg_idx_t;

  // one element pair, lane 0 in the low wen bit
  typedef struct packed {
    logic     valid;
    reg_idx_t vd;
    offset_t  woffset0;
    offset_t  woffset1;
    offset_t  vs2_offset0;
    offset_t  vs2_offset1;
    logic [1:0] wen;
    logic     last;
  } uop_t;

endpackage

`default_nettype wire

/* src/vdecode_if.sv */
`default_nettype none

`include "vdecode_defines.svh"

// decoded command, held from capture until the next one
interface ctrl_if;
  logic start;
  logic [`VD_CNT_W-1:0] count;
  logic [`VD_CNT_W-1:0] vstart;
  vdecode_pkg::reg_idx_t vd;
  vdecode_pkg::vs2_src_t vs2_src;
  vdecode_pkg::vd_src_t vd_src;
  logic vm;
  logic is_store;
  logic is_mv;
  logic [`VD_XLEN-1:0] xs1;
  vdecode_pkg::offset_t uimm;
  logic [`VD_MASK_W-1:0] mask;

  modport decode (output start, count, vstart, vd, vs2_src, vd_src, vm, is_store, is_mv,
                  xs1, uimm, mask);
  modport seq (input start, count, vstart);
  modport build (input vd, vs2_src, vd_src, vm, is_store, is_mv, xs1, uimm, mask);
endinterface

// current element pair from the sequencer
interface element_if;
  logic advance;
  logic pair_valid;
  logic [`VD_CNT_W-1:0] elem_idx;
  logic lane1_active;
  logic last;

  modport seq (output advance, pair_valid, elem_idx, lane1_active, last);
  modport build (input advance, pair_valid, elem_idx, lane1_active, last);
endinterface

`default_nettype wire

/* src/vctrl_decode.sv */
`default_nettype none

`include "vdecode_defines.svh"

module vctrl_decode (
  input logic CLK,
  input logic nRST,
  input logic req,
  input logic [31:0] instr,
  input logic [`VD_CNT_W-1:0] vl,
  input logic [`VD_CNT_W-1:0] vstart,
  input vdecode_pkg::sew_t sew,
  input logic [`VD_XLEN-1:0] xs1,
  input logic [`VD_MASK_W-1:0] mask,
  input logic seq_done,
  ctrl_if.decode ctrl
);

  localparam logic [6:0] OPC_OPV   = 7'b1010111;
  localparam logic [6:0] OPC_LOAD  = 7'b0000111;
  localparam logic [6:0] OPC_STORE = 7'b0100111;
  localparam logic [5:0] F6_SLIDEUP   = 6'b001110;
  localparam logic [5:0] F6_SLIDEDOWN = 6'b001111;
  localparam logic [5:0] F6_VMV       = 6'b010000;
  localparam logic [2:0] F3_OPIVI = 3'b011;
  localparam logic [2:0] F3_OPIVX = 3'b100;
  localparam logic [2:0] F3_OPMVX = 3'b110;

  logic idle;
  logic capture;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [5:0] funct6;
  vdecode_pkg::eew_t eew;
  vdecode_pkg::op_class_t op_class;
  vdecode_pkg::vs2_src_t vs2_src;
  vdecode_pkg::vd_src_t vd_src;
  logic [`VD_CNT_W-1:0] ls_count;
  logic [`VD_CNT_W-1:0] count;

  assign opcode  = instr[6:0];
  assign funct3  = instr[14:12];
  assign funct6  = instr[31:26];
  assign eew     = vdecode_pkg::eew_t'(funct3);
  assign capture = req & idle;

  always_comb begin : classify
    op_class = vdecode_pkg::OP_ARITH;
    vs2_src  = vdecode_pkg::VS2_NORMAL;
    vd_src   = vdecode_pkg::VD_NORMAL;
    if (opcode == OPC_OPV) begin
      if (funct3 == F3_OPMVX && funct6 == F6_VMV) begin
        op_class = vdecode_pkg::OP_MV_SX;
        vs2_src  = vdecode_pkg::VS2_ZERO;
        vd_src   = vdecode_pkg::VD_ZERO;
      end else if (funct6 == F6_SLIDEUP) begin
        // slideup moves the destination
        if (funct3 == F3_OPIVX) vd_src = vdecode_pkg::VD_PLUS_RS1;
        else if (funct3 == F3_OPIVI) vd_src = vdecode_pkg::VD_PLUS_UIMM;
      end else if (funct6 == F6_SLIDEDOWN) begin
        // slidedown moves the source
        if (funct3 == F3_OPIVX) vs2_src = vdecode_pkg::VS2_PLUS_RS1;
        else if (funct3 == F3_OPIVI) vs2_src = vdecode_pkg::VS2_PLUS_UIMM;
      end
    end else if (opcode == OPC_LOAD) begin
      op_class = vdecode_pkg::OP_LOAD;
    end else if (opcode == OPC_STORE) begin
      op_class = vdecode_pkg::OP_STORE;
    end
  end

  // unit-stride count scaled by eew against sew
  always_comb begin : ls_scale
    if (sew == vdecode_pkg::SEW32 && eew == vdecode_pkg::EEW8) begin
      ls_count = vl >> 2;
    end else if ((sew == vdecode_pkg::SEW32 && eew == vdecode_pkg::EEW16) ||
                 (sew == vdecode_pkg::SEW16 && eew == vdecode_pkg::EEW8)) begin
      ls_count = vl >> 1;
    end else begin
      ls_count = vl;
    end
  end

  always_comb begin : element_count
    case (op_class)
      vdecode_pkg::OP_MV_SX: count = `VD_CNT_W'(1);
      vdecode_pkg::OP_LOAD, vdecode_pkg::OP_STORE: count = ls_count;
      default: count = vl;
    endcase
  end

  // idle until the sequencer sees ack drop
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      idle       <= 1'b1;
      ctrl.start <= 1'b0;
    end else begin
      ctrl.start <= capture;
      if (capture) idle <= 1'b0;
      else if (seq_done) idle <= 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (capture) begin
      ctrl.count    <= count;
      ctrl.vstart   <= vstart;
      ctrl.vd       <= instr[11:7];
      ctrl.vs2_src  <= vs2_src;
      ctrl.vd_src   <= vd_src;
      ctrl.vm       <= instr[25];
      ctrl.is_store <= (op_class == vdecode_pkg::OP_STORE);
      ctrl.is_mv    <= (op_class == vdecode_pkg::OP_MV_SX);
      ctrl.xs1      <= xs1;
      ctrl.uimm     <= vdecode_pkg::offset_t'(instr[19:15]);
      ctrl.mask     <= mask;
    end
  end

endmodule

`default_nettype wire

/* src/element_sequencer.sv */
`default_nettype none

`include "vdecode_defines.svh"

module element_sequencer (
  input logic CLK,
  input logic nRST,
  input logic req,
  input logic stall,
  output logic ack,
  output logic seq_done,
  ctrl_if.seq ctrl,
  element_if.seq elem
);

  logic busy;
  logic [`VD_CNT_W-1:0] idx;
  // one extra bit so the compares near the count cannot wrap
  logic [`VD_CNT_W:0] idx_plus1;
  logic [`VD_CNT_W:0] idx_plus2;
  logic [`VD_CNT_W:0] count_ext;
  logic empty;
  logic final_pair;

  assign count_ext = {1'b0, ctrl.count};
  assign idx_plus1 = {1'b0, idx} + (`VD_CNT_W+1)'(1);
  assign idx_plus2 = {1'b0, idx} + (`VD_CNT_W+1)'(2);

  // nothing to do when vstart is at or past the count
  assign empty = (ctrl.vstart >= ctrl.count);

  assign elem.advance      = ~stall;
  assign elem.pair_valid   = busy && (idx < ctrl.count);
  assign elem.elem_idx     = idx;
  assign elem.lane1_active = (idx_plus1 < count_ext);
  assign elem.last         = elem.pair_valid && (idx_plus2 >= count_ext);

  assign final_pair = elem.advance & elem.last;

  // ack drops once req is seen low
  assign seq_done = ack & ~req;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      busy <= 1'b0;
      idx  <= '0;
    end else if (ctrl.start) begin
      busy <= ~empty;
      idx  <= ctrl.vstart;
    end else if (busy && elem.advance) begin
      idx <= idx_plus2[`VD_CNT_W-1:0];
      if (elem.last) busy <= 1'b0;
    end
  end

  // rises with the final pair, or right after start when empty
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ack <= 1'b0;
    end else if ((ctrl.start && empty) || final_pair) begin
      ack <= 1'b1;
    end else if (seq_done) begin
      ack <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* src/uop_builder.sv */
`default_nettype none

`include "vdecode_defines.svh"

module uop_builder (
  input logic CLK,
  input logic nRST,
  ctrl_if.build ctrl,
  element_if.build elem,
  output vdecode_pkg::uop_t uop
);

  localparam int MIDX_W = $clog2(`VD_MASK_W);
  localparam int CNT_W  = `VD_CNT_W;

  // lane offset, all sums wrap at the offset width
  function automatic vdecode_pkg::offset_t lane_offset(
    input vdecode_pkg::offset_t base,
    input vdecode_pkg::offset_t shift,
    input logic zero
  );
    if (zero) return '0;
    return base + shift;
  endfunction

  vdecode_pkg::offset_t base0;
  vdecode_pkg::offset_t base1;
  vdecode_pkg::offset_t xs1_off;
  vdecode_pkg::offset_t vs2_shift;
  vdecode_pkg::offset_t vd_shift;
  logic vs2_zero;
  logic vd_zero;
  logic [`VD_CNT_W-1:0] idx1;
  logic mask0;
  logic mask1;
  logic [1:0] wen;
  vdecode_pkg::uop_t next_uop;

  assign base0   = vdecode_pkg::offset_t'(elem.elem_idx);
  assign base1   = base0 + vdecode_pkg::offset_t'(1);
  assign xs1_off = ctrl.xs1[`VD_OFFSET_W-1:0];
  assign idx1    = elem.elem_idx + CNT_W'(1);

  // v0 bits for the two lanes
  assign mask0 = ctrl.mask[elem.elem_idx[MIDX_W-1:0]];
  assign mask1 = ctrl.mask[idx1[MIDX_W-1:0]];

  always_comb begin : vs2_select
    vs2_shift = '0;
    vs2_zero  = 1'b0;
    case (ctrl.vs2_src)
      vdecode_pkg::VS2_PLUS_RS1:  vs2_shift = xs1_off;
      vdecode_pkg::VS2_PLUS_UIMM: vs2_shift = ctrl.uimm;
      vdecode_pkg::VS2_ZERO:      vs2_zero = 1'b1;
      default: ;
    endcase
  end

  always_comb begin : vd_select
    vd_shift = '0;
    vd_zero  = 1'b0;
    case (ctrl.vd_src)
      vdecode_pkg::VD_PLUS_RS1:  vd_shift = xs1_off;
      vdecode_pkg::VD_PLUS_UIMM: vd_shift = ctrl.uimm;
      vdecode_pkg::VD_ZERO:      vd_zero = 1'b1;
      default: ;
    endcase
  end

  always_comb begin : write_enables
    if (ctrl.is_store) begin
      wen = 2'b00;
    end else if (ctrl.is_mv) begin
      // scalar move touches element 0 only
      wen = 2'b01;
    end else begin
      wen[0] = ctrl.vm | mask0;
      wen[1] = elem.lane1_active & (ctrl.vm | mask1);
    end
  end

  always_comb begin : build
    next_uop = '0;
    if (elem.pair_valid) begin
      next_uop.valid       = 1'b1;
      next_uop.vd          = ctrl.vd;
      next_uop.woffset0    = lane_offset(base0, vd_shift, vd_zero);
      next_uop.woffset1    = lane_offset(base1, vd_shift, vd_zero);
      next_uop.vs2_offset0 = lane_offset(base0, vs2_shift, vs2_zero);
      next_uop.vs2_offset1 = lane_offset(base1, vs2_shift, vs2_zero);
      next_uop.wen         = wen;
      next_uop.last        = elem.last;
    end
  end

  // holds while stalled, bubble when no pair is pending
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      uop <= '0;
    end else if (elem.advance) begin
      uop <= next_uop;
    end
  end

endmodule

`default_nettype wire

/* src/vdecode_stage.sv */
`default_nettype none

`include "vdecode_defines.svh"

module vdecode_stage (
  input logic CLK,
  input logic nRST,
  input logic req,
  input logic [31:0] instr,
  input logic [`VD_CNT_W-1:0] vl,
  input logic [`VD_CNT_W-1:0] vstart,
  input vdecode_pkg::sew_t sew,
  input logic [`VD_XLEN-1:0] xs1,
  input logic [`VD_MASK_W-1:0] mask,
  input logic stall,
  output logic ack,
  output logic uop_valid,
  output vdecode_pkg::reg_idx_t uop_vd,
  output vdecode_pkg::offset_t uop_woffset0,
  output vdecode_pkg::offset_t uop_woffset1,
  output vdecode_pkg::offset_t uop_vs2_offset0,
  output vdecode_pkg::offset_t uop_vs2_offset1,
  output logic [1:0] uop_wen,
  output logic uop_last
);

  logic seq_done;
  vdecode_pkg::uop_t uop;

  ctrl_if ctrl_bus ();
  element_if elem_bus ();

  vctrl_decode u_decode (
    .CLK(CLK),
    .nRST(nRST),
    .req(req),
    .instr(instr),
    .vl(vl),
    .vstart(vstart),
    .sew(sew),
    .xs1(xs1),
    .mask(mask),
    .seq_done(seq_done),
    .ctrl(ctrl_bus)
  );

  element_sequencer u_seq (
    .CLK(CLK),
    .nRST(nRST),
    .req(req),
    .stall(stall),
    .ack(ack),
    .seq_done(seq_done),
    .ctrl(ctrl_bus),
    .elem(elem_bus)
  );

  uop_builder u_build (
    .CLK(CLK),
    .nRST(nRST),
    .ctrl(ctrl_bus),
    .elem(elem_bus),
    .uop(uop)
  );

  // micro-op fields out as flat ports
  assign uop_valid       = uop.valid;
  assign uop_vd          = uop.vd;
  assign uop_woffset0    = uop.woffset0;
  assign uop_woffset1    = uop.woffset1;
  assign uop_vs2_offset0 = uop.vs2_offset0;
  assign uop_vs2_offset1 = uop.vs2_offset1;
  assign uop_wen         = uop.wen;
  assign uop_last        = uop.last;

endmodule

`default_nettype wire

/* test/tb_clock.sv */
`default_nettype none

module tb_clock (
  output logic CLK
);
  timeunit 1ns;
  timeprecision 1ps;

  // 10 ns period
  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

endmodule

`default_nettype wire

/* test/vdecode_assert.sv */
`default_nettype none

module vdecode_assert (
  input logic CLK,
  input logic nRST,
  input logic req,
  input logic ack,
  input logic uop_valid,
  input logic [1:0] uop_wen,
  input logic uop_last
);
  timeunit 1ns;
  timeprecision 1ps;

  // number of failed assertions so far
  int fail_count = 0;

  // ack only answers a pending request
  ack_needs_req: assert property (@(posedge CLK) disable iff (!nRST) $rose(ack) |-> req)
    else begin
      $error("ack rose while req was low");
      fail_count++;
    end

  wen_needs_valid: assert property (@(posedge CLK) disable iff (!nRST)
    (uop_wen != 2'b00) |-> uop_valid)
    else begin
      $error("uop_wen set on an invalid micro-op");
      fail_count++;
    end

  last_needs_valid: assert property (@(posedge CLK) disable iff (!nRST)
    uop_last |-> uop_valid)
    else begin
      $error("uop_last set on an invalid micro-op");
      fail_count++;
    end

  // four-phase, ack drops only once req is seen low
  ack_falls_after_req: assert property (@(posedge CLK) disable iff (!nRST)
    $fell(ack) |-> !$past(req))
    else begin
      $error("ack fell while req was still high");
      fail_count++;
    end

endmodule

bind vdecode_stage vdecode_assert u_assert (
  .CLK(CLK),
  .nRST(nRST),
  .req(req),
  .ack(ack),
  .uop_valid(uop_valid),
  .uop_wen(uop_wen),
  .uop_last(uop_last)
);

`default_nettype wire

/* test/vdecode_tb.sv */
`default_nettype none

`include "vdecode_defines.svh"

module vdecode_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int WAIT_LIMIT = 200;
  localparam logic [6:0] OPC_OPV = 7'b1010111;
  localparam logic [6:0] OPC_LOAD = 7'b0000111;
  localparam logic [6:0] OPC_STORE = 7'b0100111;
  localparam vdecode_pkg::sew_t S8 = vdecode_pkg::SEW8;
  localparam vdecode_pkg::sew_t S16 = vdecode_pkg::SEW16;
  localparam vdecode_pkg::sew_t S32 = vdecode_pkg::SEW32;

  typedef struct {
    logic [31:0] instr;
    int vl;
    int vstart;
    vdecode_pkg::sew_t sew;
    logic [31:0] xs1;
  } row_t;

  logic CLK;
  logic nRST;
  logic req;
  logic [31:0] instr;
  logic [`VD_CNT_W-1:0] vl;
  logic [`VD_CNT_W-1:0] vstart;
  vdecode_pkg::sew_t sew;
  logic [`VD_XLEN-1:0] xs1;
  logic [`VD_MASK_W-1:0] mask;
  logic stall;
  logic ack;
  logic uop_valid;
  vdecode_pkg::reg_idx_t uop_vd;
  vdecode_pkg::offset_t uop_woffset0;
  vdecode_pkg::offset_t uop_woffset1;
  vdecode_pkg::offset_t uop_vs2_offset0;
  vdecode_pkg::offset_t uop_vs2_offset1;
  logic [1:0] uop_wen;
  logic uop_last;

  row_t rows[$];
  vdecode_pkg::uop_t exp_q[$];
  row_t cur_row;
  logic [31:0] cur_mask;
  logic drive_req;
  logic [31:0] rng_state;
  logic applied_stall;
  logic next_stall;
  logic timed_out;
  vdecode_pkg::uop_t prev_uop;
  int errors;
  int tests_run;
  int tests_failed;
  int got_count;
  int step_count;
  int first_step;

  tb_clock u_clk (.CLK(CLK));

  vdecode_stage u_dut (.*);

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic [31:0] encode(input logic [5:0] f6, input logic vm,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] vd, input logic [6:0] opc);
    return {f6, vm, 5'd8, rs1, f3, vd, opc};
  endfunction

  function automatic vdecode_pkg::offset_t to_offset(input int v);
    return vdecode_pkg::offset_t'(v);
  endfunction

  function automatic logic mask_bit(input logic [31:0] m, input int k);
    return ((m >> k) & 32'd1) != 32'd0;
  endfunction

  function automatic vdecode_pkg::uop_t sample_uop();
    vdecode_pkg::uop_t u;
    u.valid = uop_valid;
    u.vd = uop_vd;
    u.woffset0 = uop_woffset0;
    u.woffset1 = uop_woffset1;
    u.vs2_offset0 = uop_vs2_offset0;
    u.vs2_offset1 = uop_vs2_offset1;
    u.wen = uop_wen;
    u.last = uop_last;
    return u;
  endfunction

  task automatic add_row(input logic [31:0] ins, input int row_vl, input int row_vstart,
                         input vdecode_pkg::sew_t row_sew, input logic [31:0] row_xs1);
    row_t r;
    r.instr = ins;
    r.vl = row_vl;
    r.vstart = row_vstart;
    r.sew = row_sew;
    r.xs1 = row_xs1;
    rows.push_back(r);
  endtask

  task automatic load_table();
    // arithmetic with vm set and clear, odd counts leave lane 1 off
    add_row(encode(6'b000000, 1'b1, 5'd3, 3'b000, 5'd4, OPC_OPV), 8, 0, S32, 0);
    add_row(encode(6'b000000, 1'b0, 5'd3, 3'b000, 5'd5, OPC_OPV), 7, 0, S32, 0);
    add_row(encode(6'b000000, 1'b0, 5'd3, 3'b000, 5'd6, OPC_OPV), 32, 3, S16, 0);
    // slides, .vx takes the low byte of xs1, .vi the immediate
    add_row(encode(6'b001110, 1'b1, 5'd1, 3'b100, 5'd8, OPC_OPV), 10, 0, S32, 32'h01f5);
    add_row(encode(6'b001110, 1'b0, 5'd31, 3'b011, 5'd9, OPC_OPV), 9, 0, S8, 0);
    add_row(encode(6'b001111, 1'b1, 5'd1, 3'b100, 5'd10, OPC_OPV), 6, 0, S32, 32'hfffffffe);
    add_row(encode(6'b001111, 1'b1, 5'd3, 3'b011, 5'd11, OPC_OPV), 5, 1, S32, 0);
    // unit-stride loads, width field is the eew
    add_row(encode(6'b000000, 1'b1, 5'd2, 3'b000, 5'd12, OPC_LOAD), 32, 0, S32, 0);
    add_row(encode(6'b000000, 1'b1, 5'd2, 3'b101, 5'd13, OPC_LOAD), 30, 0, S32, 0);
    add_row(encode(6'b000000, 1'b0, 5'd2, 3'b000, 5'd14, OPC_LOAD), 13, 0, S16, 0);
    add_row(encode(6'b000000, 1'b1, 5'd2, 3'b110, 5'd15, OPC_LOAD), 11, 0, S32, 0);
    add_row(encode(6'b000000, 1'b1, 5'd2, 3'b101, 5'd16, OPC_LOAD), 5, 0, S8, 0);
    add_row(encode(6'b000000, 1'b0, 5'd2, 3'b000, 5'd17, OPC_STORE), 20, 0, S32, 0);
    add_row(encode(6'b000000, 1'b1, 5'd2, 3'b110, 5'd18, OPC_STORE), 9, 0, S32, 0);
    add_row(encode(6'b010000, 1'b1, 5'd7, 3'b110, 5'd19, OPC_OPV), 16, 0, S32, 32'h1234);
    // empty, vstart at the count or a load scaled to zero
    add_row(encode(6'b000000, 1'b1, 5'd3, 3'b000, 5'd20, OPC_OPV), 4, 4, S32, 0);
    add_row(encode(6'b000000, 1'b1, 5'd2, 3'b000, 5'd21, OPC_LOAD), 3, 0, S32, 0);
  endtask

  // reference model, fills exp_q with the predicted pairs
  task automatic build_expected(input row_t r, input logic [31:0] m);
    logic [6:0] opc;
    logic [2:0] f3;
    logic [5:0] f6;
    logic vm;
    logic opv;
    logic is_mv;
    logic is_ls;
    logic is_st;
    logic lane1;
    int count;
    int shift;
    int vd_shift;
    int vs2_shift;
    vdecode_pkg::uop_t u;
    opc = r.instr[6:0];
    f3 = r.instr[14:12];
    f6 = r.instr[31:26];
    vm = r.instr[25];
    opv = (opc == OPC_OPV);
    is_mv = opv && f3 == 3'b110 && f6 == 6'b010000;
    is_st = !opv && opc == OPC_STORE;
    is_ls = is_st || (!opv && opc == OPC_LOAD);
    vd_shift = 0;
    vs2_shift = 0;
    if (opv && !is_mv && (f6 == 6'b001110 || f6 == 6'b001111)) begin
      shift = 0;
      if (f3 == 3'b100) shift = int'(r.xs1[7:0]);
      else if (f3 == 3'b011) shift = int'(r.instr[19:15]);
      if (f6 == 6'b001110) vd_shift = shift;
      else vs2_shift = shift;
    end
    count = r.vl;
    if (is_mv) begin
      count = 1;
    end else if (is_ls) begin
      if (r.sew == S32 && f3 == 3'b000) count = r.vl / 4;
      else if ((r.sew == S32 && f3 == 3'b101) || (r.sew == S16 && f3 == 3'b000))
        count = r.vl / 2;
    end
    exp_q.delete();
    for (int i = r.vstart; i < count; i += 2) begin
      lane1 = (i + 1 < count);
      u = '0;
      u.valid = 1'b1;
      u.vd = r.instr[11:7];
      u.woffset0 = is_mv ? to_offset(0) : to_offset(i + vd_shift);
      u.woffset1 = is_mv ? to_offset(0) : to_offset(i + 1 + vd_shift);
      u.vs2_offset0 = is_mv ? to_offset(0) : to_offset(i + vs2_shift);
      u.vs2_offset1 = is_mv ? to_offset(0) : to_offset(i + 1 + vs2_shift);
      if (is_st) begin
        u.wen = 2'b00;
      end else if (is_mv) begin
        u.wen = 2'b01;
      end else begin
        u.wen[0] = vm | mask_bit(m, i);
        u.wen[1] = lane1 & (vm | mask_bit(m, i + 1));
      end
      u.last = (i + 2 >= count);
      exp_q.push_back(u);
    end
  endtask

  task automatic check_offset(input string name, input vdecode_pkg::offset_t got,
                              input vdecode_pkg::offset_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_wen(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_vd(input string name, input vdecode_pkg::reg_idx_t got,
                          input vdecode_pkg::reg_idx_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_uop(input string tag, input vdecode_pkg::uop_t got,
                             input vdecode_pkg::uop_t exp);
    check_bit({tag, "uop_valid"}, got.valid, exp.valid);
    check_vd({tag, "uop_vd"}, got.vd, exp.vd);
    check_offset({tag, "uop_woffset0"}, got.woffset0, exp.woffset0);
    check_offset({tag, "uop_woffset1"}, got.woffset1, exp.woffset1);
    check_offset({tag, "uop_vs2_offset0"}, got.vs2_offset0, exp.vs2_offset0);
    check_offset({tag, "uop_vs2_offset1"}, got.vs2_offset1, exp.vs2_offset1);
    check_wen({tag, "uop_wen"}, got.wen, exp.wen);
    check_bit({tag, "uop_last"}, got.last, exp.last);
  endtask

  // one clock, drive on the rising edge and observe on the falling edge
  task automatic tick(input logic stall_on);
    vdecode_pkg::uop_t cur;
    logic s;
    s = stall_on && (next_rand() % 4 == 0);
    @(posedge CLK);
    applied_stall = next_stall;
    next_stall = s;
    stall <= s;
    req <= drive_req;
    instr <= cur_row.instr;
    vl <= `VD_CNT_W'(cur_row.vl);
    vstart <= `VD_CNT_W'(cur_row.vstart);
    sew <= cur_row.sew;
    xs1 <= cur_row.xs1;
    mask <= cur_mask;
    @(negedge CLK);
    cur = sample_uop();
    if (applied_stall) begin
      // a stalled edge keeps the register as it was
      compare_uop("held ", cur, prev_uop);
    end else if (cur.valid) begin
      if (got_count < exp_q.size()) begin
        compare_uop("", cur, exp_q[got_count]);
      end else begin
        $display("extra micro-op at %0t beyond the %0d predicted", $time, exp_q.size());
        errors++;
      end
      if (got_count == 0) first_step = step_count;
      got_count++;
    end else if (got_count > 0 && got_count < exp_q.size()) begin
      // once started, every edge without stall carries the next pair
      $display("no micro-op at %0t after %0d of %0d, stall was low", $time, got_count,
               exp_q.size());
      errors++;
    end
    prev_uop = cur;
    step_count++;
  endtask

  task automatic run_row(input int idx, input row_t r, input logic stall_on);
    int waited;
    int err_before;
    err_before = errors;
    cur_row = r;
    cur_mask = next_rand();
    build_expected(r, cur_mask);
    got_count = 0;
    step_count = 0;
    first_step = -1;
    drive_req = 1'b1;
    waited = 0;
    tick(stall_on);
    while (!ack && waited < WAIT_LIMIT) begin
      tick(stall_on);
      waited++;
    end
    if (!ack) begin
      $display("timeout, no ack within %0d cycles on row %0d", WAIT_LIMIT, idx);
      errors++;
      timed_out = 1'b1;
    end else begin
      if (got_count != exp_q.size()) begin
        $display("ack came after %0d of %0d micro-ops on row %0d", got_count, exp_q.size(), idx);
        errors++;
      end
      // without stall the first pair lands two edges after the capture
      if (!stall_on && exp_q.size() > 0 && first_step != 3) begin
        $display("first micro-op on row %0d came on cycle %0d, not 3", idx, first_step);
        errors++;
      end
      drive_req = 1'b0;
      tick(stall_on);
      if (!ack) begin
        $display("ack fell before req was seen low on row %0d", idx);
        errors++;
      end
      waited = 0;
      while (ack && waited < WAIT_LIMIT) begin
        tick(stall_on);
        waited++;
      end
      if (ack) begin
        $display("timeout, ack stayed high after req dropped on row %0d", idx);
        errors++;
        timed_out = 1'b1;
      end
    end
    tests_run++;
    if (errors != err_before) tests_failed++;
    $display("row %0d stall %0d: %0d of %0d micro-ops, %0d errors", idx, stall_on,
             got_count, exp_q.size(), errors - err_before);
  endtask

  initial begin : main
    nRST = 1'b0;
    req = 1'b0;
    instr = '0;
    vl = '0;
    vstart = '0;
    sew = S8;
    xs1 = '0;
    mask = '0;
    stall = 1'b0;
    rng_state = 32'haac7_2e44;
    cur_row = '{instr: 32'd0, vl: 0, vstart: 0, sew: S8, xs1: 32'd0};
    cur_mask = '0;
    drive_req = 1'b0;
    applied_stall = 1'b0;
    next_stall = 1'b0;
    timed_out = 1'b0;
    prev_uop = '0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    load_table();
    repeat (7) @(posedge CLK);
    @(negedge CLK);
    check_bit("ack", ack, 1'b0);
    check_bit("uop_valid", uop_valid, 1'b0);
    check_wen("uop_wen", uop_wen, 2'b00);
    check_bit("uop_last", uop_last, 1'b0);
    @(posedge CLK);
    nRST <= 1'b1;
    // second pass repeats the table under random stall
    for (int pass = 0; pass < 2 && !timed_out; pass++) begin
      for (int r = 0; r < rows.size() && !timed_out; r++) begin
        run_row(r, rows[r], pass == 1);
      end
    end
    if (u_dut.u_assert.fail_count != 0) begin
      $display("%0d assertion failures in the bound checker", u_dut.u_assert.fail_count);
      errors += u_dut.u_assert.fail_count;
    end
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+src
src/vdecode_pkg.sv
src/vdecode_if.sv
src/vctrl_decode.sv
src/element_sequencer.sv
src/uop_builder.sv
src/vdecode_stage.sv
test/tb_clock.sv
test/vdecode_assert.sv
test/vdecode_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the vector decode testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module vdecode_tb -f src.f -o vdecode_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "verilator build failed, see build.log"
  exit 1
fi

./obj_dir/vdecode_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error, see sim.log"
  exit 1
fi

# the log decides the result
if grep -qF '*** PASSED ***' sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1
